// ==== logic/apu_ch3_pkg.sv ====
package apu_ch3_pkg;

	localparam int ADDR_W = 16;

	// Channel 3 register map
	localparam logic [ADDR_W-1:0] NR30_ADDR = 16'hFF1A;
	localparam logic [ADDR_W-1:0] NR31_ADDR = 16'hFF1B;
	localparam logic [ADDR_W-1:0] NR32_ADDR = 16'hFF1C;
	localparam logic [ADDR_W-1:0] NR33_ADDR = 16'hFF1D;
	localparam logic [ADDR_W-1:0] NR34_ADDR = 16'hFF1E;
	localparam logic [ADDR_W-1:0] WAVE_BASE = 16'hFF30;
	localparam int WAVE_BYTES = 16;

	// Unused bits read back as 1
	localparam logic [7:0] NR30_MASK = 8'h7F;
	localparam logic [7:0] NR32_MASK = 8'h9F;
	localparam logic [7:0] NR34_MASK = 8'hBF;
	localparam logic [7:0] OPEN_BUS  = 8'hFF;

	localparam logic [7:0] NR_RESET  = 8'h00;

	typedef logic [3:0]  sample_t;
	typedef logic [10:0] freq_t;
	typedef logic [4:0]  wave_pos_t;
	typedef logic [7:0]  len_t;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_NR30,
		SEL_NR31,
		SEL_NR32,
		SEL_NR33,
		SEL_NR34,
		SEL_WAVE
	} reg_sel_e;

	// NR32 bits 6:5
	typedef enum logic [1:0] {
		VOL_MUTE,
		VOL_FULL,
		VOL_HALF,
		VOL_QUARTER
	} vol_code_e;

endpackage

// ==== logic/ch3_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module ch3_regs(
	input  logic                           clk_2mhz,
	input  logic                           rst_n,
	input  logic [apu_ch3_pkg::ADDR_W-1:0] addr,
	input  logic [7:0]                     wdata,
	input  logic                           wr,
	input  logic                           rd,
	output logic [7:0]                     rdata,
	output logic                           dac_on,
	output apu_ch3_pkg::len_t              len_load,
	output apu_ch3_pkg::vol_code_e         vol,
	output apu_ch3_pkg::freq_t             freq,
	output logic                           len_en,
	output logic                           trigger,
	output logic                           wave_wr,
	output logic                           wave_rd,
	output logic [3:0]                     wave_idx,
	output logic [7:0]                     wave_wdata,
	input  logic [7:0]                     wave_rdata
);

	import apu_ch3_pkg::*;

	reg_sel_e sel;
	logic [7:0] nr30, nr31, nr32, nr33, nr34;
	logic [7:0] reg_rdata;
	logic [7:0] rd_data_q;
	logic rd_wave_q;

	always_comb begin
		sel = SEL_NONE;
		if (addr[ADDR_W-1:4] == WAVE_BASE[ADDR_W-1:4]) begin
			sel = SEL_WAVE;
		end else begin
			case (addr)
				NR30_ADDR: sel = SEL_NR30;
				NR31_ADDR: sel = SEL_NR31;
				NR32_ADDR: sel = SEL_NR32;
				NR33_ADDR: sel = SEL_NR33;
				NR34_ADDR: sel = SEL_NR34;
				default:   sel = SEL_NONE;
			endcase
		end
	end

	always_ff @(posedge clk_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			nr30 <= NR_RESET;
			nr31 <= NR_RESET;
			nr32 <= NR_RESET;
			nr33 <= NR_RESET;
			nr34 <= NR_RESET;
			trigger <= 1'b0;
		end else begin
			if (wr && sel == SEL_NR30) nr30 <= wdata;
			if (wr && sel == SEL_NR31) nr31 <= wdata;
			if (wr && sel == SEL_NR32) nr32 <= wdata;
			if (wr && sel == SEL_NR33) nr33 <= wdata;
			if (wr && sel == SEL_NR34) nr34 <= wdata;
			// NR34 bit 7 is write-only, seen only as a pulse
			trigger <= wr && sel == SEL_NR34 && wdata[7];
		end
	end

	always_comb begin
		case (sel)
			SEL_NR30: reg_rdata = nr30 | NR30_MASK;
			SEL_NR32: reg_rdata = nr32 | NR32_MASK;
			SEL_NR34: reg_rdata = nr34 | NR34_MASK;
			default:  reg_rdata = OPEN_BUS;
		endcase
	end

	// Wave bytes come from the RAM's own read register
	always_ff @(posedge clk_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			rd_data_q <= OPEN_BUS;
			rd_wave_q <= 1'b0;
		end else if (rd) begin
			rd_data_q <= reg_rdata;
			rd_wave_q <= (sel == SEL_WAVE);
		end
	end

	assign rdata = rd_wave_q ? wave_rdata : rd_data_q;

	assign dac_on   = nr30[7];
	assign len_load = nr31;
	assign vol      = vol_code_e'(nr32[6:5]);
	assign freq     = {nr34[2:0], nr33};
	assign len_en   = nr34[6];

	assign wave_wr    = wr && sel == SEL_WAVE;
	assign wave_rd    = rd && sel == SEL_WAVE;
	assign wave_idx   = addr[3:0];
	assign wave_wdata = wdata;

endmodule

// ==== logic/wave_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module wave_ram(
	input  logic                   clk_2mhz,
	input  logic                   rst_n,
	input  logic                   wave_wr,
	input  logic                   wave_rd,
	input  logic [3:0]             wave_idx,
	input  logic [7:0]             wave_wdata,
	output logic [7:0]             wave_rdata,
	input  logic                   ch3_active,
	input  apu_ch3_pkg::wave_pos_t play_pos,
	output logic [7:0]             play_byte
);

	import apu_ch3_pkg::*;

	logic [7:0] mem [WAVE_BYTES];
	logic [3:0] idx;

	// While playing the CPU only reaches the byte under the play position
	assign idx = ch3_active ? play_pos[4:1] : wave_idx;

	always_ff @(posedge clk_2mhz) begin
		if (wave_wr) begin
			mem[idx] <= wave_wdata;
		end
		if (wave_rd) begin
			wave_rdata <= mem[idx];
		end
	end

	// Play read, every cycle
	always_ff @(posedge clk_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			play_byte <= 8'h00;
		end else begin
			play_byte <= mem[play_pos[4:1]];
		end
	end

endmodule

// ==== logic/ch3_freq_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module ch3_freq_timer(
	input  logic                   clk_2mhz,
	input  logic                   rst_n,
	input  apu_ch3_pkg::freq_t     freq,
	input  logic                   trigger,
	input  logic                   ch3_active,
	output apu_ch3_pkg::wave_pos_t play_pos
);

	import apu_ch3_pkg::*;

	freq_t cnt;
	logic wrap;

	assign wrap = (cnt == '1);

	// Step period is 2048 - freq cycles
	always_ff @(posedge clk_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			play_pos <= '0;
		end else if (trigger) begin
			cnt <= freq;
			play_pos <= '0;
		end else if (ch3_active) begin
			if (wrap) begin
				cnt <= freq;
				// wraps 31 -> 0 on its own
				play_pos <= play_pos + 1'b1;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

// ==== logic/ch3_length_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module ch3_length_counter(
	input  logic              clk_2mhz,
	input  logic              rst_n,
	input  apu_ch3_pkg::len_t len_load,
	input  logic              len_en,
	input  logic              len_tick,
	input  logic              trigger,
	output logic              len_expire
);

	import apu_ch3_pkg::*;

	logic [8:0] cnt;
	logic step;

	assign step = len_tick && len_en && cnt != 9'd0;

	always_ff @(posedge clk_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= 9'd0;
			len_expire <= 1'b0;
		end else begin
			len_expire <= 1'b0;
			if (trigger) begin
				// Reload only once the old length has run out
				if (cnt == 9'd0) begin
					cnt <= 9'd256 - {1'b0, len_load};
				end
			end else if (step) begin
				cnt <= cnt - 9'd1;
				len_expire <= (cnt == 9'd1);
			end
		end
	end

endmodule

// ==== logic/channel3.sv ====
`timescale 1ns/100ps
`default_nettype none

module channel3(
	input  logic                           clk_2mhz,
	input  logic                           rst_n,
	input  logic [apu_ch3_pkg::ADDR_W-1:0] addr,
	input  logic [7:0]                     wdata,
	input  logic                           wr,
	input  logic                           rd,
	output logic [7:0]                     rdata,
	input  logic                           len_tick,
	output logic                           ch3_active,
	output apu_ch3_pkg::sample_t           sample
);

	import apu_ch3_pkg::*;

	logic dac_on, len_en, trigger, len_expire;
	len_t len_load;
	vol_code_e vol;
	freq_t freq;
	logic wave_wr, wave_rd;
	logic [3:0] wave_idx;
	logic [7:0] wave_wdata, wave_rdata, play_byte;
	wave_pos_t play_pos;
	logic pos_lsb_q;
	sample_t nibble, shifted;

	ch3_regs u_regs(
		.clk_2mhz, .rst_n, .addr, .wdata, .wr, .rd, .rdata,
		.dac_on, .len_load, .vol, .freq, .len_en, .trigger,
		.wave_wr, .wave_rd, .wave_idx, .wave_wdata, .wave_rdata
	);

	wave_ram u_wave_ram(
		.clk_2mhz, .rst_n, .wave_wr, .wave_rd, .wave_idx, .wave_wdata,
		.wave_rdata, .ch3_active, .play_pos, .play_byte
	);

	ch3_freq_timer u_freq_timer(
		.clk_2mhz, .rst_n, .freq, .trigger, .ch3_active, .play_pos
	);

	ch3_length_counter u_length(
		.clk_2mhz, .rst_n, .len_load, .len_en, .len_tick, .trigger, .len_expire
	);

	// Channel enable
	always_ff @(posedge clk_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			ch3_active <= 1'b0;
		end else if (trigger && dac_on) begin
			ch3_active <= 1'b1;
		end else if (!dac_on || len_expire) begin
			ch3_active <= 1'b0;
		end
	end

	// Lines up with the registered play byte
	always_ff @(posedge clk_2mhz or negedge rst_n) begin
		if (!rst_n) begin
			pos_lsb_q <= 1'b0;
		end else begin
			pos_lsb_q <= play_pos[0];
		end
	end

	// High nibble first
	assign nibble = pos_lsb_q ? play_byte[3:0] : play_byte[7:4];

	always_comb begin
		case (vol)
			VOL_FULL:    shifted = nibble;
			VOL_HALF:    shifted = nibble >> 1;
			VOL_QUARTER: shifted = nibble >> 2;
			default:     shifted = '0;
		endcase
	end

	assign sample = ch3_active ? shifted : '0;

endmodule

// ==== verif/ch3_chk.sv ====
`timescale 1ns/100ps

module ch3_chk(
	input logic                 clk_2mhz,
	input logic                 rst_n,
	input logic                 wr,
	input logic                 rd,
	input logic [7:0]           rdata,
	input logic                 trigger,
	input logic                 ch3_active,
	input apu_ch3_pkg::sample_t sample
);

	// Output is gated by the enable
	a_mute: assert property (@(posedge clk_2mhz) disable iff (!rst_n)
		!ch3_active |-> (sample == 4'h0))
		else $error("sample is nonzero while the channel is inactive");

	// Read data only moves after a read strobe
	a_rdata_hold: assert property (@(posedge clk_2mhz) disable iff (!rst_n)
		!rd |=> $stable(rdata))
		else $error("rdata changed without a read");

	a_rise: assert property (@(posedge clk_2mhz) disable iff (!rst_n)
		$rose(ch3_active) |-> $past(trigger))
		else $error("channel became active without a trigger");

	a_bus: assert property (@(posedge clk_2mhz) disable iff (!rst_n)
		!(wr && rd))
		else $error("read and write strobes high together");

endmodule

bind channel3 ch3_chk i_chk(
	.clk_2mhz, .rst_n, .wr, .rd, .rdata, .trigger, .ch3_active, .sample
);

// ==== verif/tb_channel3.sv ====
`timescale 1ns/100ps

module tb_channel3;

	import apu_ch3_pkg::*;

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DLY   = 10;
	localparam int PLAY_CYCLES = 300;
	// Registers, wave RAM, length, playback, wave reads, DAC off
	localparam int TEST_CYCLES = 100 + 100 + 2100 + 1400 + 100 + 100;

	logic clk_2mhz, rst_n;
	logic [ADDR_W-1:0] addr;
	logic [7:0] wdata, rdata;
	logic wr, rd, len_tick, ch3_active;
	sample_t sample;

	logic [31:0] lfsr;
	int err_cnt;

	// Reference model state
	logic [7:0] m_nr30, m_nr31, m_nr32, m_nr33, m_nr34, m_rdata, m_play;
	logic [7:0] m_mem [16];
	logic m_trig, m_active, m_expire, m_lsb;
	freq_t m_cnt;
	wave_pos_t m_pos;
	logic [8:0] m_len;

	channel3 i_dut(
		.clk_2mhz, .rst_n, .addr, .wdata, .wr, .rd, .rdata,
		.len_tick, .ch3_active, .sample
	);

	initial begin
		clk_2mhz = 1'b0;
		forever #(CLK_PERIOD / 2) clk_2mhz = ~clk_2mhz;
	end

	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", 2 * TEST_CYCLES);
		$display("Finished with errors");
		$fatal(1, "Watchdog expired");
	end

	// Galois LFSR, one step per bit
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = 8'h00;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'hA300_0000 : lfsr >> 1;
		end
		return v;
	endfunction

	function automatic logic [ADDR_W-1:0] wave_addr(input logic [3:0] i);
		return {WAVE_BASE[ADDR_W-1:4], i};
	endfunction

	function automatic logic [7:0] reg_value(input logic [ADDR_W-1:0] a);
		case (a)
			NR30_ADDR: return m_nr30 | NR30_MASK;
			NR32_ADDR: return m_nr32 | NR32_MASK;
			NR34_ADDR: return m_nr34 | NR34_MASK;
			default:   return 8'hFF;
		endcase
	endfunction

	function automatic sample_t model_sample();
		sample_t nib;
		nib = m_lsb ? m_play[3:0] : m_play[7:4];
		if (!m_active) begin
			return 4'h0;
		end
		case (vol_code_e'(m_nr32[6:5]))
			VOL_FULL:    return nib;
			VOL_HALF:    return nib >> 1;
			VOL_QUARTER: return nib >> 2;
			default:     return 4'h0;
		endcase
	endfunction

	task automatic model_reset();
		{m_nr30, m_nr31, m_nr32, m_nr33, m_nr34} = '0;
		{m_trig, m_active, m_expire, m_lsb} = '0;
		m_cnt = '0;
		m_pos = '0;
		m_len = 9'd0;
		m_play = 8'h00;
		m_rdata = 8'hFF;
	endtask

	// One clock edge of the model, all terms taken from the old state
	task automatic model_step();
		logic is_wave, dac, act;
		logic [3:0] idx;
		freq_t f;
		is_wave = addr[ADDR_W-1:4] == WAVE_BASE[ADDR_W-1:4];
		idx = m_active ? m_pos[4:1] : addr[3:0];
		dac = m_nr30[7];
		f = {m_nr34[2:0], m_nr33};
		act = m_active;
		if (m_trig && dac) begin
			act = 1'b1;
		end else if (!dac || m_expire) begin
			act = 1'b0;
		end
		if (rd) begin
			m_rdata = is_wave ? m_mem[idx] : reg_value(addr);
		end
		m_play = m_mem[m_pos[4:1]];
		m_lsb = m_pos[0];
		if (wr && is_wave) begin
			m_mem[idx] = wdata;
		end
		m_expire = 1'b0;
		if (m_trig) begin
			if (m_len == 9'd0) begin
				m_len = 9'd256 - {1'b0, m_nr31};
			end
		end else if (len_tick && m_nr34[6] && m_len != 9'd0) begin
			m_expire = m_len == 9'd1;
			m_len = m_len - 9'd1;
		end
		if (m_trig) begin
			m_cnt = f;
			m_pos = '0;
		end else if (m_active && m_cnt == 11'h7FF) begin
			m_cnt = f;
			m_pos = m_pos + 5'd1;
		end else if (m_active) begin
			m_cnt = m_cnt + 11'd1;
		end
		m_active = act;
		m_trig = wr && addr == NR34_ADDR && wdata[7];
		if (wr) begin
			case (addr)
				NR30_ADDR: m_nr30 = wdata;
				NR31_ADDR: m_nr31 = wdata;
				NR32_ADDR: m_nr32 = wdata;
				NR33_ADDR: m_nr33 = wdata;
				NR34_ADDR: m_nr34 = wdata;
				default:   ;
			endcase
		end
	endtask

	task automatic stop_on_error();
		err_cnt++;
		$display("Finished with errors");
		$fatal(1, "Mismatch between DUT and model");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	// Outputs are compared just before the next drive
	task automatic cycle();
		@(posedge clk_2mhz);
		model_step();
		#DRIVE_DLY;
		check_byte("rdata", rdata, m_rdata);
		check_bit("ch3_active", ch3_active, m_active);
		check_sample("sample", sample, model_sample());
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [7:0] d);
		addr = a;
		wdata = d;
		wr = 1'b1;
		cycle();
		wr = 1'b0;
	endtask

	task automatic read_bus(input logic [ADDR_W-1:0] a);
		addr = a;
		rd = 1'b1;
		cycle();
		rd = 1'b0;
	endtask

	task automatic read_expect(input logic [ADDR_W-1:0] a, input logic [7:0] exp);
		read_bus(a);
		check_byte("rdata", rdata, exp);
	endtask

	task automatic reg_roundtrip(input logic [ADDR_W-1:0] a, input logic [7:0] mask);
		logic [7:0] d;
		d = rand_bits(8);
		// Wave RAM is not loaded yet, so no trigger
		if (a == NR34_ADDR) begin
			d[7] = 1'b0;
		end
		write_reg(a, d);
		read_expect(a, d | mask);
	endtask

	task automatic tick_len();
		len_tick = 1'b1;
		cycle();
		len_tick = 1'b0;
		repeat (3) cycle();
	endtask

	initial begin
		logic [7:0] img [16];
		logic [7:0] r;
		freq_t f;
		vol_code_e vc;
		int n;
		rst_n = 1'b0;
		addr = '0;
		wdata = 8'h00;
		wr = 1'b0;
		rd = 1'b0;
		len_tick = 1'b0;
		lfsr = 32'h43ee_8e67;
		err_cnt = 0;
		for (int i = 0; i < 16; i++) begin
			m_mem[i] = 8'h00;
		end
		model_reset();
		repeat (4) @(posedge clk_2mhz);
		#DRIVE_DLY;
		rst_n = 1'b1;

		// Output values straight out of reset
		check_byte("rdata", rdata, 8'hFF);
		check_bit("ch3_active", ch3_active, 1'b0);
		check_sample("sample", sample, 4'h0);

		// Register reset values, random round trips, unmapped reads
		read_expect(NR30_ADDR, NR30_MASK);
		read_expect(NR31_ADDR, 8'hFF);
		read_expect(NR32_ADDR, NR32_MASK);
		read_expect(NR33_ADDR, 8'hFF);
		read_expect(NR34_ADDR, NR34_MASK);
		repeat (3) begin
			reg_roundtrip(NR30_ADDR, NR30_MASK);
			reg_roundtrip(NR31_ADDR, 8'hFF);
			reg_roundtrip(NR32_ADDR, NR32_MASK);
			reg_roundtrip(NR33_ADDR, 8'hFF);
			reg_roundtrip(NR34_ADDR, NR34_MASK);
		end
		read_expect(16'hFF19, 8'hFF);
		read_expect(16'hFF1F, 8'hFF);
		read_expect(16'hFF2F, 8'hFF);
		read_expect(16'hFF40, 8'hFF);
		read_expect(16'h0000, 8'hFF);

		// Wave RAM while inactive
		for (int i = 0; i < 16; i++) begin
			img[i] = rand_bits(8);
			write_reg(wave_addr(i[3:0]), img[i]);
		end
		for (int i = 0; i < 16; i++) begin
			read_expect(wave_addr(i[3:0]), img[i]);
		end

		// Length expiry after 256 - NR31 ticks
		r = rand_bits(8);
		n = 256 - int'(r);
		write_reg(NR31_ADDR, r);
		write_reg(NR32_ADDR, 8'h20);
		write_reg(NR33_ADDR, rand_bits(8));
		write_reg(NR30_ADDR, 8'h80);
		write_reg(NR34_ADDR, 8'hC7);
		cycle();
		repeat (n - 1) tick_len();
		check_bit("ch3_active", ch3_active, 1'b1);
		tick_len();
		check_bit("ch3_active", ch3_active, 1'b0);
		// Same tick count with length off must not expire
		write_reg(NR34_ADDR, 8'h87);
		cycle();
		repeat (n) tick_len();
		check_bit("ch3_active", ch3_active, 1'b1);

		// Playback at each volume code
		for (int k = 0; k < 4; k++) begin
			write_reg(NR30_ADDR, 8'h00);
			cycle();
			for (int i = 0; i < 16; i++) begin
				write_reg(wave_addr(i[3:0]), rand_bits(8));
			end
			r = rand_bits(4);
			f = 11'h7FF - {7'd0, r[3:0]};
			vc = vol_code_e'(k[1:0]);
			write_reg(NR32_ADDR, {1'b0, vc, 5'b0_0000});
			write_reg(NR33_ADDR, f[7:0]);
			write_reg(NR30_ADDR, 8'h80);
			write_reg(NR34_ADDR, {5'b1000_0, f[10:8]});
			repeat (PLAY_CYCLES) cycle();
		end

		// CPU wave reads land on the play byte
		repeat (24) begin
			r = rand_bits(4);
			read_bus(wave_addr(r[3:0]));
			cycle();
		end

		// DAC off stops the channel and blocks a new trigger
		write_reg(NR30_ADDR, 8'h00);
		cycle();
		check_bit("ch3_active", ch3_active, 1'b0);
		check_sample("sample", sample, 4'h0);
		write_reg(NR34_ADDR, 8'h87);
		repeat (4) cycle();
		check_bit("ch3_active", ch3_active, 1'b0);

		if (err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
logic/apu_ch3_pkg.sv
logic/ch3_regs.sv
logic/wave_ram.sv
logic/ch3_freq_timer.sv
logic/ch3_length_counter.sv
logic/channel3.sv
verif/ch3_chk.sv
verif/tb_channel3.sv

// ==== Makefile ====
# Verilator flow for the channel 3 testbench
VERILATOR ?= verilator
TOP       ?= tb_channel3
BUILD_DIR ?= build
LOG       ?= sim.log
FLIST     ?= flist.f
VFLAGS    ?= --timing --assert
PASS_MSG  := Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
